// ==== core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// ###########################################################################
// core dimensions
// ###########################################################################

// width of a machine word and of every operand and result
`define CORE_XLEN 64

// architectural integer registers, rax through r15
`define CORE_NUM_REGS 16

// a register code is the REX extension bit on top of the 3-bit ModRM field
`define CORE_REG_BITS 4

`endif

// ==== isaPkg.sv ====
`include "core_config.svh"

package isaPkg;

   typedef logic [`CORE_XLEN-1:0]     word_t;
   typedef logic [`CORE_REG_BITS-1:0] regCode_t;
   typedef logic [31:0]               imm_t;

   // REX prefix byte laid out as 0100WRXB
   typedef struct packed {
      logic [3:0] fixed;
      logic       w;      // 64-bit operand size
      logic       r;      // extends ModRM.reg
      logic       x;      // SIB index extension, has no effect with mod = 3
      logic       b;      // extends ModRM.rm
   } rex_t;

   typedef struct packed {
      logic [1:0] mode;
      logic [2:0] regOp;  // register operand or opcode extension
      logic [2:0] rm;
   } modRm_t;

   localparam logic [3:0] REX_FIXED = 4'b0100;
   localparam logic [1:0] MOD_REG   = 2'b11;  // both operands are registers

   typedef enum logic [7:0] {
      OP_ADD     = 8'h01,
      OP_SUB     = 8'h29,
      OP_AND     = 8'h21,
      OP_OR      = 8'h09,
      OP_XOR     = 8'h31,
      OP_ADD_IMM = 8'h81,  // group 1, only /0 is taken
      OP_MOV_IMM = 8'hC7   // only /0 is defined
   } opcode_t;

   typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS} aluOp_t;

   // imm32 operands of 64-bit instructions are sign-extended
   function automatic word_t signExtend(input imm_t imm);
      return word_t'($signed(imm));
   endfunction

endpackage

// ==== pipePkg.sv ====
package pipePkg;

   // ###########################################################################
   // instruction as it arrives, already aligned
   // ###########################################################################

   typedef struct packed {
      isaPkg::rex_t   rex;
      logic [7:0]     opcode;
      isaPkg::modRm_t modRm;
      isaPkg::imm_t   imm;
   } rawInstr_t;

   // ###########################################################################
   // stage bundles
   // ###########################################################################

   typedef struct packed {
      logic             valid;
      logic             illegal;
      isaPkg::aluOp_t   aluOp;
      isaPkg::regCode_t src1;
      logic             src1Valid;
      isaPkg::regCode_t src2;
      logic             src2Valid;
      logic             useImm;     // operand 2 comes from imm instead of src2
      isaPkg::word_t    imm;        // already sign-extended
      isaPkg::regCode_t dest;
   } decoded_t;

   typedef struct packed {
      logic             valid;
      logic             illegal;
      isaPkg::aluOp_t   aluOp;
      isaPkg::word_t    operand1;
      isaPkg::word_t    operand2;
      isaPkg::regCode_t src1;       // source codes ride along so execute can bypass
      logic             src1Valid;
      isaPkg::regCode_t src2;
      logic             src2Valid;
      isaPkg::regCode_t dest;
   } readBundle_t;

   typedef struct packed {
      logic             valid;
      logic             illegal;
      isaPkg::regCode_t dest;
      isaPkg::word_t    value;
      logic             zero;
      logic             sign;
   } result_t;

endpackage

// ==== Decode.sv ====
`timescale 1ns/1ps

module Decode (
   input  logic               clk,
   input  logic               reset,
   input  logic               instrValid,
   input  pipePkg::rawInstr_t instr,
   output pipePkg::decoded_t  decoded
);
   import isaPkg::*;
   import pipePkg::*;

   decoded_t next;
   opcode_t  opcode;
   regCode_t regCode;   // REX.R on top of ModRM.reg
   regCode_t rmCode;    // REX.B on top of ModRM.rm
   logic     formOk;
   logic     opcodeOk;

   always_comb begin
      opcode   = opcode_t'(instr.opcode);
      regCode  = {instr.rex.r, instr.modRm.regOp};
      rmCode   = {instr.rex.b, instr.modRm.rm};
      formOk   = (instr.rex.fixed == REX_FIXED) && instr.rex.w &&
                 (instr.modRm.mode == MOD_REG);
      opcodeOk = 1'b1;

      next       = '0;
      next.valid = instrValid;
      next.imm   = signExtend(instr.imm);
      next.dest  = rmCode;  // r/m is always the destination in these forms
      next.src1  = rmCode;
      next.src2  = regCode;

      case (opcode)
         OP_ADD: next.aluOp = ALU_ADD;
         OP_SUB: next.aluOp = ALU_SUB;
         OP_AND: next.aluOp = ALU_AND;
         OP_OR:  next.aluOp = ALU_OR;
         OP_XOR: next.aluOp = ALU_XOR;
         OP_ADD_IMM: begin
            next.aluOp  = ALU_ADD;
            next.useImm = 1'b1;
            opcodeOk    = (instr.modRm.regOp == 3'd0);  // /0 selects ADD in group 1
         end
         OP_MOV_IMM: begin
            next.aluOp  = ALU_PASS;
            next.useImm = 1'b1;
            opcodeOk    = (instr.modRm.regOp == 3'd0);
         end
         default: opcodeOk = 1'b0;
      endcase

      // MOV overwrites the destination, so it reads nothing
      next.src1Valid = (opcode != OP_MOV_IMM);
      next.src2Valid = !next.useImm;

      if (!(formOk && opcodeOk)) begin
         next.illegal   = 1'b1;
         next.aluOp     = ALU_PASS;
         next.useImm    = 1'b0;
         next.src1Valid = 1'b0;  // no sources, nothing to read or bypass
         next.src2Valid = 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      decoded <= next;
      if (reset) begin
         decoded.valid <= 1'b0;
      end
   end

   // an illegal encoding must never pull a register into the read stage
   assert property (@(posedge clk) disable iff (reset)
      decoded.valid && decoded.illegal |-> !decoded.src1Valid);

endmodule

// ==== Read.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module Read (
   input  logic                 clk,
   input  logic                 reset,
   input  pipePkg::decoded_t    decoded,
   input  isaPkg::word_t        regFile [`CORE_NUM_REGS],
   output pipePkg::readBundle_t readOut
);
   import pipePkg::*;

   readBundle_t next;

   // ###########################################################################
   // operand fetch
   // ###########################################################################

   always_comb begin
      // sources that are not used read as zero
      next.operand1 = decoded.src1Valid ? regFile[decoded.src1] : '0;

      if (decoded.useImm) begin
         next.operand2 = decoded.imm;
      end else if (decoded.src2Valid) begin
         next.operand2 = regFile[decoded.src2];
      end else begin
         next.operand2 = '0;
      end

      // the rest goes through as decoded
      next.valid     = decoded.valid;
      next.illegal   = decoded.illegal;
      next.aluOp     = decoded.aluOp;
      next.dest      = decoded.dest;

      next.src1      = decoded.src1;  // execute compares these against the last result
      next.src1Valid = decoded.src1Valid;
      next.src2      = decoded.src2;
      next.src2Valid = decoded.src2Valid;
   end

   always_ff @(posedge clk) begin
      readOut <= next;
      if (reset) begin
         readOut.valid <= 1'b0;
      end
   end

   // an X code here would index the register file with garbage and later
   // defeat the bypass compare in execute
   assert property (@(posedge clk) disable iff (reset)
      decoded.valid |-> !(decoded.src1Valid && $isunknown(decoded.src1)) &&
                        !(decoded.src2Valid && $isunknown(decoded.src2)));

endmodule

// ==== Execute.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module Execute (
   input  logic                 clk,
   input  logic                 reset,
   input  pipePkg::readBundle_t readIn,
   input  pipePkg::result_t     lastResult,
   output pipePkg::result_t     result
);
   import isaPkg::*;
   import pipePkg::*;

   word_t   opA;
   word_t   opB;
   word_t   aluOut;
   logic    lastWrites;
   result_t next;

   // only a legal result actually lands in the register file
   assign lastWrites = lastResult.valid && !lastResult.illegal;

   // the instruction right ahead has not reached the register file when
   // this one read it, so its value is taken from the result register
   function automatic word_t bypass(input word_t fromRead, input regCode_t code,
                                    input logic codeValid);
      if (codeValid && lastWrites && (lastResult.dest == code)) begin
         return lastResult.value;
      end
      return fromRead;
   endfunction

   // ###########################################################################
   // ALU and flags
   // ###########################################################################

   always_comb begin
      opA = bypass(readIn.operand1, readIn.src1, readIn.src1Valid);
      opB = bypass(readIn.operand2, readIn.src2, readIn.src2Valid);

      case (readIn.aluOp)
         ALU_ADD:  aluOut = opA + opB;
         ALU_SUB:  aluOut = opA - opB;  // r/m minus reg, as x86 orders it
         ALU_AND:  aluOut = opA & opB;
         ALU_OR:   aluOut = opA | opB;
         ALU_XOR:  aluOut = opA ^ opB;
         ALU_PASS: aluOut = opB;        // MOV, operand 2 holds the immediate
         default:  aluOut = '0;
      endcase

      next.valid   = readIn.valid;
      next.illegal = readIn.illegal;
      next.dest    = readIn.dest;
      next.value   = readIn.illegal ? '0 : aluOut;

      // illegal results carry no flags
      next.zero    = !readIn.illegal && (next.value == '0);
      next.sign    = next.value[`CORE_XLEN-1];
   end

   always_ff @(posedge clk) begin
      result <= next;
      if (reset) begin
         result.valid <= 1'b0;
      end
   end

   // decode only ever hands out one of the six operations
   assert property (@(posedge clk) disable iff (reset)
      readIn.valid |-> readIn.aluOp inside {ALU_ADD, ALU_SUB, ALU_AND,
                                           ALU_OR, ALU_XOR, ALU_PASS});

endmodule

// ==== Writeback.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module Writeback (
   input  logic             clk,
   input  logic             reset,
   input  pipePkg::result_t result,
   output isaPkg::word_t    regFile [`CORE_NUM_REGS],
   output pipePkg::result_t resultOut
);
   import isaPkg::*;

   word_t regStore [`CORE_NUM_REGS];
   logic  regWrite;

   assign regWrite = result.valid && !result.illegal;

   // ###########################################################################
   // register file
   // ###########################################################################

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `CORE_NUM_REGS; i++) begin
            regStore[i] <= '0;
         end
      end else if (regWrite) begin
         regStore[result.dest] <= result.value;
      end
   end

   // the result being retired shows up in the read port right away, so an
   // instruction two behind sees it without going through the bypass
   always_comb begin
      for (int i = 0; i < `CORE_NUM_REGS; i++) begin
         if (regWrite && (result.dest == regCode_t'(i))) begin
            regFile[i] = result.value;
         end else begin
            regFile[i] = regStore[i];
         end
      end
   end

   // the same result goes out of the core and back to execute for the bypass
   assign resultOut = result;

   // an illegal instruction leaves its destination register as it was
   assert property (@(posedge clk) disable iff (reset)
      result.valid && result.illegal |=>
         regStore[$past(result.dest)] == $past(regStore[result.dest]));

endmodule

// ==== Core.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module Core (
   input  logic               clk,
   input  logic               reset,
   input  logic               instrValid,
   input  pipePkg::rawInstr_t instr,
   output logic               resultValid,
   output pipePkg::result_t   result
);
   import isaPkg::*;
   import pipePkg::*;

   decoded_t    decoded;
   readBundle_t readBundle;
   result_t     executed;
   word_t       regFile [`CORE_NUM_REGS];

   // ###########################################################################
   // decode, read, execute, writeback
   // ###########################################################################

   Decode Decode_inst (
      .clk        (clk),
      .reset      (reset),
      .instrValid (instrValid),
      .instr      (instr),
      .decoded    (decoded)
   );

   Read Read_inst (
      .clk     (clk),
      .reset   (reset),
      .decoded (decoded),
      .regFile (regFile),
      .readOut (readBundle)
   );

   Execute Execute_inst (
      .clk        (clk),
      .reset      (reset),
      .readIn     (readBundle),
      .lastResult (result),     // bypass source for the next instruction
      .result     (executed)
   );

   Writeback Writeback_inst (
      .clk       (clk),
      .reset     (reset),
      .result    (executed),
      .regFile   (regFile),
      .resultOut (result)
   );

   assign resultValid = result.valid;

endmodule

// ==== CoreTb.sv ====
`timescale 1ns/1ps

module CoreTb;
   import isaPkg::*;
   import pipePkg::*;

   // what one stimulus line promises for its result
   typedef struct packed {
      regCode_t dest;
      word_t    value;
      logic     zero;
      logic     sign;
      logic     illegal;
   } expect_t;

   logic      clk;
   logic      reset;
   logic      instrValid;
   rawInstr_t instr;
   logic      resultValid;
   result_t   result;

   rawInstr_t stimInstr [$];
   expect_t   stimExpect [$];
   bit        stimChain [$];   // 1 issues the line with no idle cycle before it
   expect_t   pending [$];     // issued in order, popped as results come back
   int        lineCount;
   int        checkedCount;
   int        cycleCount = 0;
   int        cycleLimit;
   int        seed;

   Core Core_inst (
      .clk         (clk),
      .reset       (reset),
      .instrValid  (instrValid),
      .instr       (instr),
      .resultValid (resultValid),
      .result      (result)
   );

   always #2 clk = ~clk;   // 4 ns period

   // ##########################################################################
   // stopping and comparing
   // ##########################################################################

   task automatic abortRun(input string reason);
      $display("Verification failed");
      $fatal(1, "%s", reason);
   endtask

   task automatic checkWord(input word_t got, input word_t exp, input string what);
      if (got !== exp) begin
         $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
         abortRun("result value mismatch");
      end
   endtask

   task automatic checkReg(input regCode_t got, input regCode_t exp, input string what);
      if (got !== exp) begin
         $display("FAILED at %0t: %s is r%0d, expected r%0d", $time, what, got, exp);
         abortRun("destination register mismatch");
      end
   endtask

   task automatic checkFlag(input bit got, input bit exp, input string what);
      if (got !== exp) begin
         $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
         abortRun("flag mismatch");
      end
   endtask

   // ##########################################################################
   // stimulus file
   // ##########################################################################

   task automatic loadStimulus();
      int         fd;
      int         fields;
      string      line;
      logic [7:0] rexByte;
      logic [7:0] opByte;
      logic [7:0] modRmByte;
      imm_t       imm;
      regCode_t   destCode;
      word_t      value;
      logic       zeroBit;
      logic       signBit;
      logic       illegalBit;
      logic       chain;
      rawInstr_t  raw;
      expect_t    exp;
      fd = $fopen("coreStim.txt", "r");
      if (fd == 0) begin
         $display("could not open the stimulus file coreStim.txt");
         abortRun("missing stimulus file");
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() >= 4 && line.getc(0) != "#") begin   // skip comments and blanks
               fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", rexByte, opByte,
                                modRmByte, imm, destCode, value, zeroBit, signBit,
                                illegalBit, chain);
               if (fields != 10) begin
                  $display("malformed stimulus line: %s", line);
                  abortRun("bad stimulus file");
               end else begin
                  raw         = {rexByte, opByte, modRmByte, imm};
                  exp.dest    = destCode;
                  exp.value   = value;
                  exp.zero    = zeroBit;
                  exp.sign    = signBit;
                  exp.illegal = illegalBit;
                  stimInstr.push_back(raw);
                  stimExpect.push_back(exp);
                  stimChain.push_back(chain);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // ##########################################################################
   // result monitor and cycle limit
   // ##########################################################################

   // result is registered in the DUT, so the value seen at the edge is last cycle's
   always @(posedge clk) begin
      expect_t exp;
      if (!reset && resultValid) begin
         if (pending.size() == 0) begin
            $display("a result arrived at %0t with no instruction outstanding", $time);
            abortRun("unexpected result");
         end else begin
            exp = pending.pop_front();
            checkReg(result.dest, exp.dest, "dest");
            checkWord(result.value, exp.value, "value");
            checkFlag(result.zero, exp.zero, "zero flag");
            checkFlag(result.sign, exp.sign, "sign flag");
            checkFlag(result.illegal, exp.illegal, "illegal bit");
            checkedCount = checkedCount + 1;
         end
      end
   end

   always @(posedge clk) begin
      cycleCount = cycleCount + 1;
      if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
         $display("timeout: %0d of %0d results checked after %0d cycles",
                  checkedCount, lineCount, cycleLimit);
         abortRun("simulation timeout");
      end
   end

   initial begin
      int gap;
      seed         = 32'hd86;
      clk          = 1'b0;
      reset        = 1'b1;
      instrValid   = 1'b0;
      instr        = '0;
      checkedCount = 0;
      cycleLimit   = 0;

      loadStimulus();
      lineCount  = stimInstr.size();
      cycleLimit = lineCount * 3 + 20;   // at most 2 idle cycles per line, plus latency

      repeat (2) @(posedge clk);
      reset <= 1'b0;

      for (int i = 0; i < lineCount; i++) begin
         gap = stimChain[i] ? 0 : int'($unsigned($random(seed)) % 3);
         repeat (gap) begin
            instrValid <= 1'b0;
            @(posedge clk);
         end
         instrValid <= 1'b1;
         instr      <= stimInstr[i];
         pending.push_back(stimExpect[i]);
         @(posedge clk);
      end
      instrValid <= 1'b0;

      wait (checkedCount == lineCount);
      repeat (5) @(posedge clk);   // a surplus result would show up here
      if (checkedCount == lineCount && pending.size() == 0) begin
         $display("Verification passed");
         $finish;
      end else begin
         abortRun("result count does not match the issued instructions");
      end
   end

endmodule

// ==== coreStim.txt ====
# rex op modrm imm dest value zero sign illegal chain, all in hex
# chain 1 issues the line right after the previous one, 0 allows a random idle gap
48 c7 c0 00000005 0 0000000000000005 0 0 0 0
48 c7 c1 fffffffd 1 fffffffffffffffd 0 1 0 0
48 c7 c2 7fffffff 2 000000007fffffff 0 0 0 0
48 c7 c3 80000000 3 ffffffff80000000 0 1 0 0
48 c7 c4 0000000c 4 000000000000000c 0 0 0 0
48 c7 c5 0000000a 5 000000000000000a 0 0 0 0
48 c7 c6 00000000 6 0000000000000000 1 0 0 0
48 c7 c7 12345678 7 0000000012345678 0 0 0 0
49 c7 c0 00000008 8 0000000000000008 0 0 0 0
49 c7 c1 ffffffff 9 ffffffffffffffff 0 1 0 0
49 c7 c2 00001000 a 0000000000001000 0 0 0 0
49 c7 c3 0000000b b 000000000000000b 0 0 0 0
49 c7 c4 f0000000 c fffffffff0000000 0 1 0 0
49 c7 c5 00000003 d 0000000000000003 0 0 0 0
49 c7 c6 00000070 e 0000000000000070 0 0 0 0
49 c7 c7 00000055 f 0000000000000055 0 0 0 0
48 01 e8 00000000 0 000000000000000f 0 0 0 0
48 29 e4 00000000 4 0000000000000000 1 0 0 0
48 29 fd 00000000 5 ffffffffedcba992 0 1 0 0
4c 21 f7 00000000 7 0000000000000070 0 0 0 0
4d 09 e8 00000000 8 000000000000000b 0 0 0 0
4d 31 cf 00000000 f ffffffffffffffaa 0 1 0 0
4d 31 db 00000000 b 0000000000000000 1 0 0 0
48 01 d1 00000000 1 000000007ffffffc 0 0 0 0
48 01 c9 00000000 1 00000000fffffff8 0 0 0 1
48 29 c8 00000000 0 ffffffff00000017 0 1 0 1
48 21 cb 00000000 3 0000000080000000 0 0 0 1
49 09 c2 00000000 a ffffffff00001017 0 1 0 1
4d 31 d4 00000000 c 00000000f0001017 0 0 0 1
49 81 c5 fffffffe d 0000000000000001 0 0 0 0
49 81 c5 ffffffff d 0000000000000000 1 0 0 1
48 81 c2 00000001 2 0000000080000000 0 0 0 0
49 01 06 00000000 e 0000000000000000 0 0 1 0
41 01 c6 00000000 e 0000000000000000 0 0 1 0
49 89 c6 00000000 e 0000000000000000 0 0 1 1
49 81 ee 00000001 e 0000000000000000 0 0 1 1
4d 09 f6 00000000 e 0000000000000070 0 0 0 1

// ==== compile.f ====
+incdir+.
isaPkg.sv
pipePkg.sv
Decode.sv
Read.sv
Execute.sv
Writeback.sv
Core.sv
CoreTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= CoreTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
